//--- run_sim.sh
#!/usr/bin/env bash
# build and run the warp issue testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_warp_issue -f sources.f -o sim_warp_issue \
    && ./obj_dir/sim_warp_issue | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/ibuffer_warp.sv
`timescale 1ns/1ns

module ibuffer_warp #(
    parameter int NUM_THREADS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    // decode side
    input  logic                   wr_en,
    input  isa_pkg::instr_word_t   dec_instr,
    input  isa_pkg::opnd_t         dec_src1,
    input  isa_pkg::opnd_t         dec_src2,
    input  isa_pkg::opnd_t         dec_dst,
    input  logic                   dec_mem_read,
    input  logic                   dec_mem_write,
    input  logic                   dec_exit,
    input  logic [NUM_THREADS-1:0] active_mask,
    output logic                   fetch_req,
    // scoreboard side
    input  logic                   scb_full,
    input  logic                   scb_empty,
    input  logic                   scb_dependent,
    input  issue_pkg::scb_id_t     alloc_id,
    output isa_pkg::opnd_t         chk_src1,
    output isa_pkg::opnd_t         chk_src2,
    output isa_pkg::opnd_t         chk_dst,
    output logic                   deposit,
    output logic                   replay_done,
    output issue_pkg::scb_id_t     done_id,
    // arbiter side
    output logic                   issue_req,
    input  logic                   issue_grant,
    output logic                   exit_req,
    input  logic                   exit_grant,
    input  logic                   fb_pos,
    input  logic [NUM_THREADS-1:0] fb_mask,
    input  logic                   fb_zero,
    // selected entry towards the OC
    output isa_pkg::instr_word_t   out_instr,
    output isa_pkg::opnd_t         out_src1,
    output isa_pkg::opnd_t         out_src2,
    output isa_pkg::opnd_t         out_dst,
    output issue_pkg::scb_id_t     out_scb_id,
    output logic                   out_replay
);
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int IW = $clog2(IB_DEPTH);

    instr_word_t            instr_q [IB_DEPTH];
    opnd_t                  src1_q [IB_DEPTH];
    opnd_t                  src2_q [IB_DEPTH];
    opnd_t                  dst_q [IB_DEPTH];
    logic [NUM_THREADS-1:0] mask_q [IB_DEPTH];  // private active mask
    scb_id_t                scb_q [IB_DEPTH];
    logic [IB_DEPTH-1:0]    mem_q, exit_q;

    logic [IB_DEPTH-1:0]    valid_q, replay_q;
    logic [IB_DEPTH-1:0]    valid_nxt, replay_nxt;
    ib_ptr_t                wp, rp, irp;  // write, read, in-flight replay
    ib_ptr_t                rp_nxt, depth;
    logic [IW-1:0]          wi, ri, ii;
    logic                   full;
    logic [NUM_THREADS-1:0] mask_nxt;
    logic                   fb_again;
    logic                   rp_req, irp_req, rp_grant, irp_grant;

    assign wi = wp[IW-1:0];
    assign ri = rp[IW-1:0];
    assign ii = irp[IW-1:0];

    assign depth     = wp - irp;  // irp holds the oldest live entry
    assign full      = depth == ib_ptr_t'(IB_DEPTH);
    assign fetch_req = (depth + ib_ptr_t'(wr_en)) < ib_ptr_t'(IB_DEPTH);

    //////////////////////////////////////////////////
    // memory feedback on the in-flight entry
    assign mask_nxt    = fb_pos ? (mask_q[ii] & ~fb_mask) : mask_q[ii];
    assign fb_again    = fb_zero || (fb_pos && mask_nxt != '0);  // threads left over
    assign replay_done = fb_pos && mask_nxt == '0;
    assign done_id     = scb_q[ii];

    //////////////////////////////////////////////////
    // request selection
    always_comb begin
        rp_req  = 1'b0;
        irp_req = 1'b0;
        if (rp == irp || !valid_q[ii]) begin
            rp_req = valid_q[ri] && !exit_q[ri] && !scb_full && !scb_dependent;
        end else if (replay_q[ii] || fb_again) begin
            irp_req = 1'b1;  // replay beats new work
        end else if (valid_q[ri] && !mem_q[ri]) begin
            // one memory op in flight per warp
            rp_req = !exit_q[ri] && !scb_full && !scb_dependent;
        end
    end

    assign issue_req = rp_req || irp_req;
    assign rp_grant  = rp_req && issue_grant;
    assign irp_grant = irp_req && issue_grant;
    assign deposit   = rp_grant;  // first issue only
    assign exit_req  = valid_q[ri] && exit_q[ri] && scb_empty;
    assign rp_nxt    = rp + ib_ptr_t'(rp_grant || exit_grant);

    always_comb begin
        valid_nxt  = valid_q;
        replay_nxt = replay_q;
        if (replay_done) valid_nxt[ii] = 1'b0;
        if (rp_grant && !mem_q[ri]) valid_nxt[ri] = 1'b0;  // not replayable, gone
        if (exit_grant) valid_nxt[ri] = 1'b0;
        if (fb_again) replay_nxt[ii] = 1'b1;
        if (irp_grant) replay_nxt[ii] = 1'b0;
        if (wr_en) begin
            valid_nxt[wi]  = 1'b1;
            replay_nxt[wi] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wp       <= '0;
            rp       <= '0;
            irp      <= '0;
            valid_q  <= '0;
            replay_q <= '0;
        end else begin
            wp       <= wp + ib_ptr_t'(wr_en);
            rp       <= rp_nxt;
            irp      <= valid_nxt[ii] ? irp : rp_nxt;  // skip to next live entry
            valid_q  <= valid_nxt;
            replay_q <= replay_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (fb_pos) mask_q[ii] <= mask_nxt;
        if (rp_grant) scb_q[ri] <= alloc_id;
        if (wr_en) begin
            instr_q[wi] <= dec_instr;
            src1_q[wi]  <= dec_src1;
            src2_q[wi]  <= dec_src2;
            dst_q[wi]   <= dec_dst;
            mem_q[wi]   <= dec_mem_read || dec_mem_write;
            exit_q[wi]  <= dec_exit;
            mask_q[wi]  <= active_mask;
        end
    end

    //////////////////////////////////////////////////
    // outputs
    assign out_instr  = irp_req ? instr_q[ii] : instr_q[ri];
    assign out_src1   = irp_req ? src1_q[ii] : src1_q[ri];
    assign out_src2   = irp_req ? src2_q[ii] : src2_q[ri];
    assign out_dst    = irp_req ? dst_q[ii] : dst_q[ri];
    assign out_scb_id = irp_req ? scb_q[ii] : alloc_id;  // new id on first issue
    assign out_replay = irp_req;

    assign chk_src1 = src1_q[ri];
    assign chk_src2 = src2_q[ri];
    assign chk_dst  = dst_q[ri];

    a_no_write_full: assert property (@(posedge clk) disable iff (!rst)
        wr_en |-> !full);

    // memory must only answer for the instruction in flight
    a_done_live: assert property (@(posedge clk) disable iff (!rst)
        replay_done |-> valid_q[ii] && rp != irp);

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

    localparam int REG_ID_W = 5;
    localparam int INSTR_W  = 32;

    // architectural register number
    typedef logic [REG_ID_W-1:0] reg_id_t;

    typedef logic [INSTR_W-1:0] instr_word_t;  // raw word, decoded again by the OC

    // operand as the operand collector sees it
    typedef struct packed {
        logic    valid;  // msb
        reg_id_t id;
    } opnd_t;

    // both operands present and naming the same register
    function automatic logic opnd_match(opnd_t a, opnd_t b);
        return a.valid && b.valid && (a.id == b.id);
    endfunction

endpackage

//--- source/issue_arbiter.sv
`timescale 1ns/1ns

module issue_arbiter #(
    parameter int NUM_WARPS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_WARPS-1:0]         issue_req,
    input  logic [NUM_WARPS-1:0]         exit_req,
    input  logic                         mem_fb_pos,
    input  logic                         mem_fb_zero,
    input  logic [$clog2(NUM_WARPS)-1:0] mem_fb_warp,
    output logic [NUM_WARPS-1:0]         issue_grant,
    output logic [NUM_WARPS-1:0]         exit_grant,
    output logic [NUM_WARPS-1:0]         exit_done,
    output logic [NUM_WARPS-1:0]         fb_pos,
    output logic [NUM_WARPS-1:0]         fb_zero
);
    localparam int WW = $clog2(NUM_WARPS);

    logic [WW-1:0] rr_ptr;  // warp with top priority this cycle
    logic [WW-1:0] win;

    // nearest requester at or after rr_ptr wins
    always_comb begin
        int idx;
        issue_grant = '0;
        win         = rr_ptr;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_WARPS;
            if (issue_req[idx]) win = WW'(idx);
        end
        if (|issue_req) issue_grant[win] = 1'b1;
    end

    assign exit_grant = exit_req & (~exit_req + 1'b1);  // lowest set bit

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            fb_pos[w]  = mem_fb_pos && mem_fb_warp == WW'(w);
            fb_zero[w] = mem_fb_zero && mem_fb_warp == WW'(w);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rr_ptr    <= '0;
            exit_done <= '0;
        end else begin
            if (|issue_req) rr_ptr <= WW'((int'(win) + 1) % NUM_WARPS);
            exit_done <= exit_grant;
        end
    end

    // with every warp asking twice in a row the grant has to move on
    a_grant_rotates: assert property (@(posedge clk) disable iff (!rst)
        &issue_req && $past(&issue_req) |-> issue_grant != $past(issue_grant));

endmodule

//--- source/issue_pkg.sv
package issue_pkg;

    localparam int IB_DEPTH    = 4;  // instruction buffer entries per warp
    localparam int SCB_ENTRIES = 4;  // scoreboard entries per warp

    typedef logic [$clog2(SCB_ENTRIES)-1:0] scb_id_t;

    // one bit above the entry index tells full from empty
    typedef logic [$clog2(IB_DEPTH):0] ib_ptr_t;

endpackage

//--- source/warp_issue_top.sv
`timescale 1ns/1ns

module warp_issue_top #(
    parameter int NUM_THREADS = 8,
    parameter int NUM_WARPS   = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dec_valid,
    input  logic [$clog2(NUM_WARPS)-1:0] dec_warp,
    input  isa_pkg::instr_word_t         dec_instr,
    input  isa_pkg::opnd_t               dec_src1,
    input  isa_pkg::opnd_t               dec_src2,
    input  isa_pkg::opnd_t               dec_dst,
    input  logic                         dec_mem_read,
    input  logic                         dec_mem_write,
    input  logic                         dec_exit,
    input  logic [NUM_THREADS-1:0]       active_mask,
    input  logic                         wb_valid,
    input  logic [$clog2(NUM_WARPS)-1:0] wb_warp,
    input  issue_pkg::scb_id_t           wb_scb_id,
    input  logic                         mem_fb_pos,
    input  logic                         mem_fb_zero,
    input  logic [$clog2(NUM_WARPS)-1:0] mem_fb_warp,
    input  logic [NUM_THREADS-1:0]       mem_fb_mask,
    output logic [NUM_WARPS-1:0]         fetch_req,
    output logic                         issue_valid,
    output logic [$clog2(NUM_WARPS)-1:0] issue_warp,
    output isa_pkg::instr_word_t         issue_instr,
    output isa_pkg::opnd_t               issue_src1,
    output isa_pkg::opnd_t               issue_src2,
    output isa_pkg::opnd_t               issue_dst,
    output issue_pkg::scb_id_t           issue_scb_id,
    output logic                         issue_replay,
    output logic [NUM_WARPS-1:0]         exit_done
);
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int WW = $clog2(NUM_WARPS);

    logic [NUM_WARPS-1:0] issue_req, issue_grant;
    logic [NUM_WARPS-1:0] exit_req, exit_grant;
    logic [NUM_WARPS-1:0] fb_pos, fb_zero;
    logic [NUM_WARPS-1:0] w_replay;
    instr_word_t          w_instr [NUM_WARPS];
    opnd_t                w_src1 [NUM_WARPS];
    opnd_t                w_src2 [NUM_WARPS];
    opnd_t                w_dst [NUM_WARPS];
    scb_id_t              w_scb_id [NUM_WARPS];

    //////////////////////////////////////////////////
    // one buffer and scoreboard per warp
    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        opnd_t   chk_src1, chk_src2, chk_dst;
        scb_id_t alloc_id, done_id;
        logic    scb_full, scb_empty, scb_dependent;
        logic    deposit, replay_done;

        ibuffer_warp #(
            .NUM_THREADS(NUM_THREADS)
        ) u_ibuf (
            .clk(clk), .rst(rst),
            .wr_en(dec_valid && dec_warp == WW'(w)),
            .dec_instr(dec_instr), .dec_src1(dec_src1), .dec_src2(dec_src2),
            .dec_dst(dec_dst), .dec_mem_read(dec_mem_read),
            .dec_mem_write(dec_mem_write), .dec_exit(dec_exit),
            .active_mask(active_mask), .fetch_req(fetch_req[w]),
            .scb_full(scb_full), .scb_empty(scb_empty),
            .scb_dependent(scb_dependent), .alloc_id(alloc_id),
            .chk_src1(chk_src1), .chk_src2(chk_src2), .chk_dst(chk_dst),
            .deposit(deposit), .replay_done(replay_done), .done_id(done_id),
            .issue_req(issue_req[w]), .issue_grant(issue_grant[w]),
            .exit_req(exit_req[w]), .exit_grant(exit_grant[w]),
            .fb_pos(fb_pos[w]), .fb_mask(mem_fb_mask), .fb_zero(fb_zero[w]),
            .out_instr(w_instr[w]), .out_src1(w_src1[w]), .out_src2(w_src2[w]),
            .out_dst(w_dst[w]), .out_scb_id(w_scb_id[w]), .out_replay(w_replay[w])
        );

        warp_scoreboard u_scb (
            .clk(clk), .rst(rst),
            .chk_src1(chk_src1), .chk_src2(chk_src2), .chk_dst(chk_dst),
            .deposit(deposit),
            .clear_wb(wb_valid && wb_warp == WW'(w)), .clear_wb_id(wb_scb_id),
            .clear_replay(replay_done), .clear_replay_id(done_id),
            .full(scb_full), .empty(scb_empty), .dependent(scb_dependent),
            .alloc_id(alloc_id)
        );
    end

    issue_arbiter #(
        .NUM_WARPS(NUM_WARPS)
    ) u_arb (
        .clk(clk), .rst(rst),
        .issue_req(issue_req), .exit_req(exit_req),
        .mem_fb_pos(mem_fb_pos), .mem_fb_zero(mem_fb_zero), .mem_fb_warp(mem_fb_warp),
        .issue_grant(issue_grant), .exit_grant(exit_grant), .exit_done(exit_done),
        .fb_pos(fb_pos), .fb_zero(fb_zero)
    );

    //////////////////////////////////////////////////
    // granted warp onto the OC port
    always_comb begin
        issue_valid  = |issue_grant;
        issue_warp   = '0;
        issue_instr  = '0;
        issue_src1   = '0;
        issue_src2   = '0;
        issue_dst    = '0;
        issue_scb_id = '0;
        issue_replay = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (issue_grant[w]) begin
                issue_warp   = WW'(w);
                issue_instr  = w_instr[w];
                issue_src1   = w_src1[w];
                issue_src2   = w_src2[w];
                issue_dst    = w_dst[w];
                issue_scb_id = w_scb_id[w];
                issue_replay = w_replay[w];
            end
        end
    end

endmodule

//--- source/warp_scoreboard.sv
`timescale 1ns/1ns

module warp_scoreboard (
    input  logic               clk,
    input  logic               rst,
    input  isa_pkg::opnd_t     chk_src1,
    input  isa_pkg::opnd_t     chk_src2,
    input  isa_pkg::opnd_t     chk_dst,
    input  logic               deposit,
    input  logic               clear_wb,
    input  issue_pkg::scb_id_t clear_wb_id,
    input  logic               clear_replay,
    input  issue_pkg::scb_id_t clear_replay_id,
    output logic               full,
    output logic               empty,
    output logic               dependent,
    output issue_pkg::scb_id_t alloc_id
);
    import isa_pkg::*;
    import issue_pkg::*;

    opnd_t                  dst_q [SCB_ENTRIES];  // invalid dst for stores
    logic [SCB_ENTRIES-1:0] busy_q;
    logic [SCB_ENTRIES-1:0] hit;

    assign full  = &busy_q;
    assign empty = ~|busy_q;

    // lowest free entry
    always_comb begin
        alloc_id = '0;
        for (int i = SCB_ENTRIES - 1; i >= 0; i--) begin
            if (!busy_q[i]) alloc_id = scb_id_t'(i);
        end
    end

    // RAW on either source, WAW on the destination
    always_comb begin
        for (int i = 0; i < SCB_ENTRIES; i++) begin
            hit[i] = busy_q[i] && (opnd_match(chk_src1, dst_q[i])
                                || opnd_match(chk_src2, dst_q[i])
                                || opnd_match(chk_dst, dst_q[i]));
        end
    end

    assign dependent = |hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q <= '0;
        end else begin
            if (clear_wb) busy_q[clear_wb_id] <= 1'b0;
            if (clear_replay) busy_q[clear_replay_id] <= 1'b0;
            if (deposit) busy_q[alloc_id] <= 1'b1;  // alloc_id is never a cleared one
        end
    end

    always_ff @(posedge clk) begin
        if (deposit) dst_q[alloc_id] <= chk_dst;
    end

    a_no_deposit_full: assert property (@(posedge clk) disable iff (!rst)
        deposit |-> !full);

    // writeback only for an entry that is still outstanding
    a_wb_live: assert property (@(posedge clk) disable iff (!rst)
        clear_wb |-> busy_q[clear_wb_id]);

endmodule

//--- sources.f
source/isa_pkg.sv
source/issue_pkg.sv
source/ibuffer_warp.sv
source/warp_scoreboard.sv
source/issue_arbiter.sv
source/warp_issue_top.sv
tests/tb_warp_issue.sv

//--- tests/tb_warp_issue.sv
`timescale 1ns/1ns

module tb_warp_issue;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int NUM_THREADS = 8;
    localparam int NUM_WARPS   = 2;
    localparam int MAX_CYCLES  = 200;  // bound on trace cycles
    localparam int NUM_COLS    = 24;

    logic                   clk;
    logic                   rst;
    logic                   dec_valid;
    logic                   dec_warp;
    instr_word_t            dec_instr;
    opnd_t                  dec_src1, dec_src2, dec_dst;
    logic                   dec_mem_read, dec_mem_write, dec_exit;
    logic [NUM_THREADS-1:0] active_mask;
    logic                   wb_valid;
    logic                   wb_warp;
    scb_id_t                wb_scb_id;
    logic                   mem_fb_pos, mem_fb_zero;
    logic                   mem_fb_warp;
    logic [NUM_THREADS-1:0] mem_fb_mask;
    logic [NUM_WARPS-1:0]   fetch_req;
    logic                   issue_valid;
    logic                   issue_warp;
    instr_word_t            issue_instr;
    opnd_t                  issue_src1, issue_src2, issue_dst;
    scb_id_t                issue_scb_id;
    logic                   issue_replay;
    logic [NUM_WARPS-1:0]   exit_done;

    logic [31:0] col [NUM_COLS];  // one parsed trace line
    int          fd;
    int          cycles;
    logic        timed_out;

    // operands each instruction word was written with
    opnd_t       src1_seen [instr_word_t];
    opnd_t       src2_seen [instr_word_t];
    opnd_t       dst_seen [instr_word_t];

    warp_issue_top #(
        .NUM_THREADS(NUM_THREADS),
        .NUM_WARPS(NUM_WARPS)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // drive one trace line, check just before the next edge
    task automatic run_cycle(input string line);
        int n;
        n = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
            col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
            col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
        if (n != NUM_COLS) begin
            abort_run($sformatf("trace line has %0d fields instead of %0d: %s",
                                n, NUM_COLS, line));
        end else begin
            dec_valid     = col[0][0];
            dec_warp      = col[1][0];
            dec_instr     = col[2];
            dec_src1      = col[3][5:0];
            dec_src2      = col[4][5:0];
            dec_dst       = col[5][5:0];
            dec_mem_read  = col[6][0];
            dec_mem_write = col[7][0];
            dec_exit      = col[8][0];
            active_mask   = col[9][NUM_THREADS-1:0];
            wb_valid      = col[10][0];
            wb_warp       = col[11][0];
            wb_scb_id     = col[12][1:0];
            mem_fb_pos    = col[13][0];
            mem_fb_zero   = col[14][0];
            mem_fb_warp   = col[15][0];
            mem_fb_mask   = col[16][NUM_THREADS-1:0];
            if (dec_valid) begin
                src1_seen[dec_instr] = dec_src1;
                src2_seen[dec_instr] = dec_src2;
                dst_seen[dec_instr]  = dec_dst;
            end
            #80;
            check_value("issue_valid", 32'(issue_valid), col[17]);
            check_value("issue_warp", 32'(issue_warp), col[18]);
            check_value("issue_instr", issue_instr, col[19]);
            check_value("issue_replay", 32'(issue_replay), col[20]);
            check_value("issue_scb_id", 32'(issue_scb_id), col[21]);
            check_value("exit_done", 32'(exit_done), col[22]);
            check_value("fetch_req", 32'(fetch_req), col[23]);
            if (col[17][0] && !dst_seen.exists(col[19])) begin
                abort_run($sformatf("instruction %0h is expected to issue but was never written",
                                    col[19]));
            end else if (col[17][0]) begin
                // operands travel with the issued word, replays included
                check_value("issue_src1", 32'(issue_src1), 32'(src1_seen[col[19]]));
                check_value("issue_src2", 32'(issue_src2), 32'(src2_seen[col[19]]));
                check_value("issue_dst", 32'(issue_dst), 32'(dst_seen[col[19]]));
            end
            @(posedge clk);
            #10;
        end
    endtask

    task automatic run_trace();
        string line;
        logic  more;
        more = 1'b1;
        while (more) begin
            if (cycles == MAX_CYCLES) begin
                timed_out = 1'b1;
                more      = 1'b0;
            end else if ($fgets(line, fd) == 0) begin
                more = 1'b0;  // end of file
            end else if (line.len() > 1 && line[0] != "#") begin
                run_cycle(line);
                cycles++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        rst           = 1'b0;
        dec_valid     = 1'b0;
        dec_warp      = 1'b0;
        dec_instr     = '0;
        dec_src1      = '0;
        dec_src2      = '0;
        dec_dst       = '0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_exit      = 1'b0;
        active_mask   = '0;
        wb_valid      = 1'b0;
        wb_warp       = 1'b0;
        wb_scb_id     = '0;
        mem_fb_pos    = 1'b0;
        mem_fb_zero   = 1'b0;
        mem_fb_warp   = 1'b0;
        mem_fb_mask   = '0;
        cycles        = 0;
        timed_out     = 1'b0;
        fd = $fopen("tests/warp_issue_trace.txt", "r");
        repeat (4) @(posedge clk);
        #10 rst = 1'b1;
        if (fd == 0) begin
            abort_run("the trace file tests/warp_issue_trace.txt could not be opened");
        end else begin
            run_trace();
            $fclose(fd);
            if (timed_out) begin
                abort_run($sformatf("trace did not end within %0d cycles", MAX_CYCLES));
            end else if (cycles == 0) begin
                abort_run("the trace file holds no cycles");
            end else begin
                $display("NO ERRORS");
                $finish;
            end
        end
    end

endmodule

//--- tests/warp_issue_trace.txt
# in:  dec_valid dec_warp instr src1 src2 dst mem_rd mem_wr exit mask wb_v wb_warp wb_id fb_pos fb_zero fb_warp fb_mask
# exp: issue_valid issue_warp issue_instr issue_replay issue_scb_id exit_done fetch_req (hex)
1 0 00000011 21 00 2a 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000012 22 00 2b 0 0 0 ff  0 0 0  0 0 0 00  1 0 00000011 0 0 0 3
1 0 00000013 23 00 2c 0 0 0 ff  0 0 0  0 0 0 00  1 0 00000012 0 1 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000013 0 2 0 3
1 0 00000014 2a 00 2d 0 0 0 ff  1 0 1  0 0 0 00  0 0 00000000 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  1 0 0  0 0 0 00  0 0 00000000 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000014 0 0 0 3
1 1 00000030 00 00 34 0 0 0 ff  1 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000021 2c 00 2e 0 0 0 ff  0 0 0  0 0 0 00  1 1 00000030 0 0 0 3
1 0 00000022 21 00 2f 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 1 00000031 34 00 35 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 1 00000032 26 00 36 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000023 00 00 30 0 0 0 ff  1 0 2  0 0 0 00  0 0 00000000 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  1 1 0  0 0 0 00  1 0 00000021 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 1 00000031 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000022 0 1 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 1 00000032 0 1 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000023 0 2 0 3
1 1 00000041 27 00 37 1 0 0 ff  1 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 1 00000042 28 00 38 0 0 0 ff  1 0 1  0 0 0 00  1 1 00000041 0 2 0 3
0 0 00000000 00 00 00 0 0 0 00  1 0 2  1 0 1 0f  1 1 00000041 1 2 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 1 00000042 0 3 0 3
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 1 1 00  1 1 00000041 1 2 0 3
1 1 00000043 37 00 39 0 0 0 ff  0 0 0  1 0 1 f0  0 0 00000000 0 0 0 3
0 0 00000000 00 00 00 0 0 0 00  1 1 0  0 0 0 00  1 1 00000043 0 2 0 3
1 1 0000004f 00 00 00 0 0 1 ff  1 1 1  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000051 00 00 29 0 0 0 ff  1 1 2  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000052 29 00 22 0 0 0 ff  1 1 3  0 0 0 00  1 0 00000051 0 0 0 3
1 0 00000053 00 00 23 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 3
1 0 00000054 00 00 24 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 2 3
1 0 00000055 00 00 25 0 0 0 ff  0 0 0  0 0 0 00  0 0 00000000 0 0 0 2
0 0 00000000 00 00 00 0 0 0 00  1 0 0  0 0 0 00  0 0 00000000 0 0 0 2
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000052 0 0 0 2
0 0 00000000 00 00 00 0 0 0 00  0 0 0  0 0 0 00  1 0 00000053 0 1 0 3
